/* logic/slc3_pkg.sv */
//--------------------------------------------------------------------------
// Shared widths, opcodes, instruction views and stage structs of the SLC-3
// core. Every RTL module takes it with a wildcard import in its header.
//--------------------------------------------------------------------------
package slc3_pkg;

    localparam int XLEN = 16;
    localparam int NREGS = 8;
    localparam logic [XLEN-1:0] PC_RESET = 16'h3000;

    // LC-3 opcode encodings, PAUSE takes the reserved slot
    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ADD   = 4'b0001,
        OP_JSR   = 4'b0100,
        OP_AND   = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_NOT   = 4'b1001,
        OP_JMP   = 4'b1100,
        OP_PAUSE = 4'b1101
    } op_e;

    // --------------------------------------------------------------------------
    // Instruction word views
    // --------------------------------------------------------------------------

    // Operate view, base+offset6 is {imm_flag, imm_sr2}
    typedef struct packed {
        logic [3:0] opcode;
        logic [2:0] dr;
        logic [2:0] sr1;
        logic       imm_flag;
        logic [4:0] imm_sr2;
    } operate_t;

    // Offset view, JSR pcoffset11 is {nzp_dr[1:0], off9}
    typedef struct packed {
        logic [3:0] opcode;
        logic [2:0] nzp_dr;
        logic [8:0] off9;
    } offset_t;

    typedef union packed {
        operate_t opr;
        offset_t  ofs;
    } instr_u;

    // --------------------------------------------------------------------------
    // Stage traffic
    // --------------------------------------------------------------------------

    typedef struct packed {
        op_e             op;
        logic [2:0]      dr;
        logic [2:0]      sr1;
        logic [2:0]      sr2;
        logic            use_imm;
        logic [XLEN-1:0] imm;
        logic [2:0]      nzp;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] alu;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] store_data;
    } exec_t;

    typedef struct packed {
        logic            we;
        logic [2:0]      dr;
        logic [XLEN-1:0] data;
    } wback_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXEC,
        MEM,
        WRITE,
        PAUSED
    } phase_e;

    // Wishbone classic master side
    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        logic [XLEN-1:0] adr;
        logic [XLEN-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] dat;
    } wb_rsp_t;

endpackage

/* logic/slc3_decode.sv */
//--------------------------------------------------------------------------
// Instruction register, field decode and the multicycle sequencer.
// Drives the decoded control word and the phase to the other stages.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module slc3_decode import slc3_pkg::*; (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            run_i,
    input  logic            continue_i,
    input  logic [XLEN-1:0] fetch_word_i,
    input  logic            bus_done_i,
    output ctrl_t           ctrl_o,
    output phase_e          phase_o,
    output logic [11:0]     led_o,
    output logic            paused_o
);

    instr_u ir_q;
    ctrl_t  ctrl_d;
    ctrl_t  ctrl_q;
    phase_e phase_d;
    phase_e phase_q;
    op_e    op;

    // Instruction register, loaded when the fetch is acked
    always_ff @(posedge clk) begin
        if (phase_q == FETCH && bus_done_i) begin
            ir_q <= fetch_word_i;
        end
    end

    // --------------------------------------------------------------------------
    // Field decode
    // --------------------------------------------------------------------------

    assign op = op_e'(ir_q.opr.opcode);

    always_comb begin
        ctrl_d     = '0;
        ctrl_d.op  = op;
        ctrl_d.dr  = ir_q.opr.dr;
        ctrl_d.sr1 = ir_q.opr.sr1;
        ctrl_d.sr2 = ir_q.opr.imm_sr2[2:0];
        case (op)
            OP_ADD, OP_AND: begin
                ctrl_d.use_imm = ir_q.opr.imm_flag;
                ctrl_d.imm     = {{(XLEN-5){ir_q.opr.imm_sr2[4]}}, ir_q.opr.imm_sr2};
            end
            OP_LDR, OP_STR: begin
                // STR source register sits in the dr slot
                ctrl_d.sr2 = ir_q.opr.dr;
                ctrl_d.imm = {{(XLEN-6){ir_q.opr.imm_flag}}, ir_q.opr.imm_flag,
                              ir_q.opr.imm_sr2};
            end
            OP_BR: begin
                ctrl_d.nzp = ir_q.ofs.nzp_dr;
                ctrl_d.imm = {{(XLEN-9){ir_q.ofs.off9[8]}}, ir_q.ofs.off9};
            end
            OP_JSR: begin
                ctrl_d.dr  = 3'd7;
                ctrl_d.imm = {{(XLEN-11){ir_q.ofs.nzp_dr[1]}}, ir_q.ofs.nzp_dr[1:0],
                              ir_q.ofs.off9};
            end
            // NOT and JMP keep a zero offset
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ctrl_q <= '0;
        end else if (phase_q == DECODE) begin
            ctrl_q <= ctrl_d;
        end
    end

    // --------------------------------------------------------------------------
    // Sequencer
    // --------------------------------------------------------------------------

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            IDLE:    if (run_i) phase_d = FETCH;
            FETCH:   if (bus_done_i) phase_d = DECODE;
            DECODE:  phase_d = EXEC;
            EXEC: begin
                if (ctrl_q.op inside {OP_LDR, OP_STR}) begin
                    phase_d = MEM;
                end else if (ctrl_q.op == OP_PAUSE) begin
                    phase_d = PAUSED;
                end else begin
                    phase_d = WRITE;
                end
            end
            MEM:     if (bus_done_i) phase_d = WRITE;
            WRITE:   phase_d = FETCH;
            PAUSED:  if (continue_i) phase_d = FETCH;
            default: phase_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            phase_q <= IDLE;
        end else begin
            phase_q <= phase_d;
        end
    end

    assign ctrl_o   = ctrl_q;
    assign phase_o  = phase_q;
    assign paused_o = (phase_q == PAUSED);
    assign led_o    = paused_o ? ir_q.opr[11:0] : 12'h000;

    // Memory phase only follows a load or store decode
    a_mem_only_ldst: assert property (@(posedge clk) disable iff (reset_i)
        (phase_q != MEM) ##1 (phase_q == MEM) |-> (ctrl_q.op inside {OP_LDR, OP_STR}))
        else $error("MEM phase entered for op %0h", ctrl_q.op);

endmodule

/* logic/slc3_execute.sv */
//--------------------------------------------------------------------------
// Register file, ALU and address adder. Reads are combinational from the
// decoded control word, the write port is fed back from the result stage.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module slc3_execute import slc3_pkg::*; (
    input  logic            clk,
    input  logic            reset_i,
    input  ctrl_t           ctrl_i,
    input  logic [XLEN-1:0] pc_i,
    input  wback_t          wback_i,
    output exec_t           exec_o
);

    logic [XLEN-1:0] rf_q [NREGS];
    logic [XLEN-1:0] sr1_val;
    logic [XLEN-1:0] sr2_val;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] alu_val;
    logic [XLEN-1:0] addr_base;

    // --------------------------------------------------------------------------
    // Register file
    // --------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NREGS; i++) begin
                rf_q[i] <= '0;
            end
        end else if (wback_i.we) begin
            rf_q[wback_i.dr] <= wback_i.data;
        end
    end

    // Two read ports
    assign sr1_val = rf_q[ctrl_i.sr1];
    assign sr2_val = rf_q[ctrl_i.sr2];

    // --------------------------------------------------------------------------
    // ALU
    // --------------------------------------------------------------------------

    assign operand_b = ctrl_i.use_imm ? ctrl_i.imm : sr2_val;

    always_comb begin
        case (ctrl_i.op)
            OP_ADD:  alu_val = sr1_val + operand_b;
            OP_AND:  alu_val = sr1_val & operand_b;
            OP_NOT:  alu_val = ~sr1_val;
            default: alu_val = sr1_val;
        endcase
    end

    // --------------------------------------------------------------------------
    // Address adder
    // --------------------------------------------------------------------------

    // PC-relative for BR and JSR, otherwise base register
    always_comb begin
        if (ctrl_i.op == OP_BR || ctrl_i.op == OP_JSR) begin
            addr_base = pc_i;
        end else begin
            addr_base = sr1_val;
        end
    end

    assign exec_o.alu        = alu_val;
    assign exec_o.addr       = addr_base + ctrl_i.imm;
    assign exec_o.store_data = sr2_val;

    // Writeback index is known and inside the file
    a_wr_in_range: assert property (@(posedge clk) disable iff (reset_i)
        wback_i.we |-> !$isunknown(wback_i.dr) && (int'(wback_i.dr) < NREGS))
        else $error("register write to bad index %0d", wback_i.dr);

endmodule

/* logic/slc3_result.sv */
//--------------------------------------------------------------------------
// PC, condition codes, branch decision, writeback and the Wishbone master.
// Bus cycles follow the sequencer phase, one transaction per FETCH or MEM.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module slc3_result import slc3_pkg::*; (
    input  logic            clk,
    input  logic            reset_i,
    input  ctrl_t           ctrl_i,
    input  phase_e          phase_i,
    input  exec_t           exec_i,
    input  wb_rsp_t         wb_rsp_i,
    output wb_req_t         wb_req_o,
    output logic [XLEN-1:0] fetch_word_o,
    output logic            bus_done_o,
    output logic [XLEN-1:0] pc_o,
    output wback_t          wback_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] mdr_q;
    logic            n_q;
    logic            z_q;
    logic            p_q;
    logic            in_mem;
    logic            br_taken;
    logic            redirect;
    logic            cc_load;

    // --------------------------------------------------------------------------
    // Wishbone master
    // --------------------------------------------------------------------------

    assign in_mem = (phase_i == MEM);

    // Request held for the whole phase, phase moves on at ack
    always_comb begin
        wb_req_o.cyc = (phase_i == FETCH) || in_mem;
        wb_req_o.stb = wb_req_o.cyc;
        wb_req_o.we  = in_mem && (ctrl_i.op == OP_STR);
        wb_req_o.adr = in_mem ? exec_i.addr : pc_q;
        wb_req_o.dat = exec_i.store_data;
    end

    assign bus_done_o   = wb_req_o.cyc && wb_req_o.stb && wb_rsp_i.ack;
    assign fetch_word_o = wb_rsp_i.dat;

    // Load data is only valid in the ack cycle
    always_ff @(posedge clk) begin
        if (in_mem && bus_done_o) begin
            mdr_q <= wb_rsp_i.dat;
        end
    end

    // --------------------------------------------------------------------------
    // Writeback
    // --------------------------------------------------------------------------

    always_comb begin
        wback_o.dr = ctrl_i.dr;
        wback_o.we = (phase_i == WRITE) &&
                     (ctrl_i.op inside {OP_ADD, OP_AND, OP_NOT, OP_LDR, OP_JSR});
        case (ctrl_i.op)
            OP_LDR:  wback_o.data = mdr_q;
            // Return address, PC already points past the JSR
            OP_JSR:  wback_o.data = pc_q;
            default: wback_o.data = exec_i.alu;
        endcase
    end

    // --------------------------------------------------------------------------
    // PC and condition codes
    // --------------------------------------------------------------------------

    assign br_taken = (ctrl_i.op == OP_BR) && |(ctrl_i.nzp & {n_q, z_q, p_q});
    assign redirect = br_taken || (ctrl_i.op == OP_JMP) || (ctrl_i.op == OP_JSR);
    assign cc_load  = wback_o.we && (ctrl_i.op != OP_JSR);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= PC_RESET;
        end else if (phase_i == FETCH && bus_done_o) begin
            pc_q <= pc_q + 1'b1;
        end else if (phase_i == WRITE && redirect) begin
            pc_q <= exec_i.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            n_q <= 1'b0;
            z_q <= 1'b1;
            p_q <= 1'b0;
        end else if (cc_load) begin
            n_q <= wback_o.data[XLEN-1];
            z_q <= (wback_o.data == '0);
            p_q <= !wback_o.data[XLEN-1] && (wback_o.data != '0);
        end
    end

    assign pc_o = pc_q;

    // Bus handshake rules
    a_stb_cyc: assert property (@(posedge clk) disable iff (reset_i)
        wb_req_o.stb |-> wb_req_o.cyc)
        else $error("stb without cyc");

    a_adr_hold: assert property (@(posedge clk) disable iff (reset_i)
        (wb_req_o.stb && !wb_rsp_i.ack) |=> wb_req_o.stb && $stable(wb_req_o.adr))
        else $error("request changed before ack");

endmodule

/* logic/slc3_cpu.sv */
//--------------------------------------------------------------------------
// SLC-3 core top level. Joins decode, execute and result and exposes one
// Wishbone classic master port plus the run, pause and LED controls.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module slc3_cpu import slc3_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        run_i,
    input  logic        continue_i,
    input  wb_rsp_t     wb_rsp_i,
    output wb_req_t     wb_req_o,
    output logic [11:0] led_o,
    output logic        paused_o
);

    ctrl_t           ctrl;
    phase_e          phase;
    exec_t           exec;
    wback_t          wback;
    logic [XLEN-1:0] fetch_word;
    logic            bus_done;
    logic [XLEN-1:0] pc;

    slc3_decode u_decode (
        .clk          (clk),
        .reset_i      (reset_i),
        .run_i        (run_i),
        .continue_i   (continue_i),
        .fetch_word_i (fetch_word),
        .bus_done_i   (bus_done),
        .ctrl_o       (ctrl),
        .phase_o      (phase),
        .led_o        (led_o),
        .paused_o     (paused_o)
    );

    slc3_execute u_execute (
        .clk     (clk),
        .reset_i (reset_i),
        .ctrl_i  (ctrl),
        .pc_i    (pc),
        .wback_i (wback),
        .exec_o  (exec)
    );

    slc3_result u_result (
        .clk          (clk),
        .reset_i      (reset_i),
        .ctrl_i       (ctrl),
        .phase_i      (phase),
        .exec_i       (exec),
        .wb_rsp_i     (wb_rsp_i),
        .wb_req_o     (wb_req_o),
        .fetch_word_o (fetch_word),
        .bus_done_o   (bus_done),
        .pc_o         (pc),
        .wback_o      (wback)
    );

endmodule

/* dv/slc3_mem_model.sv */
//--------------------------------------------------------------------------
// Wishbone classic slave memory for the SLC-3 testbench, 64K words, with a
// random number of wait states before each registered ack.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module slc3_mem_model import slc3_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o
);

    logic [XLEN-1:0] mem [0:65535];
    integer          seed;
    logic            busy_q;
    logic [1:0]      wait_q;

    // Background fill from both address bytes
    initial begin
        seed = 41;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = a[15:0] ^ {a[7:0], a[15:8]} ^ 16'h5A3C;
        end
    end

    always @(posedge clk) begin
        wb_rsp_o.ack <= 1'b0;
        if (reset_i) begin
            busy_q <= 1'b0;
        end else if (wb_req_i.cyc && wb_req_i.stb && !wb_rsp_o.ack) begin
            if (!busy_q) begin
                // New request, pick 0 to 3 wait states
                busy_q <= 1'b1;
                wait_q <= 2'($random(seed) & 3);
            end else if (wait_q != 2'd0) begin
                wait_q <= wait_q - 2'd1;
            end else begin
                busy_q <= 1'b0;
                wb_rsp_o.ack <= 1'b1;
                wb_rsp_o.dat <= mem[wb_req_i.adr];
                if (wb_req_i.we) begin
                    mem[wb_req_i.adr] = wb_req_i.dat;
                end
            end
        end
    end

endmodule

/* dv/slc3_ref_model.svh */
//--------------------------------------------------------------------------
// Instruction-level model of the SLC-3 subset. Included inside the testbench
// module, it runs the loaded program and queues the expected stores and pauses.
//--------------------------------------------------------------------------
`ifndef SLC3_REF_MODEL_SVH
`define SLC3_REF_MODEL_SVH

logic [15:0] ref_mem [0:65535];
logic [15:0] exp_addr_q [$];
logic [15:0] exp_data_q [$];
logic [11:0] exp_led_q [$];

// Sign-extend the low bits of a field to a full word
function automatic logic [15:0] sext(input logic [15:0] v, input int bits);
    logic signed [15:0] t;
    t = v << (16 - bits);
    return t >>> (16 - bits);
endfunction

function automatic void run_reference(input logic [11:0] last_code, input int max_steps);
    logic [15:0] r [NREGS];
    logic [15:0] pc;
    logic [15:0] ir;
    logic [15:0] val;
    logic [15:0] ea;
    logic [2:0]  cc;
    logic        wr;
    for (int i = 0; i < NREGS; i++) begin
        r[i] = '0;
    end
    pc = PC_RESET;
    cc = 3'b010;
    for (int step = 0; step < max_steps; step++) begin
        ir = ref_mem[pc];
        pc = pc + 16'd1;
        wr = 1'b0;
        val = '0;
        case (ir[15:12])
            4'b0001, 4'b0101: begin
                ea = ir[5] ? sext(ir[4:0], 5) : r[ir[2:0]];
                val = (ir[15:12] == 4'b0001) ? r[ir[8:6]] + ea : r[ir[8:6]] & ea;
                wr = 1'b1;
            end
            4'b1001: begin
                val = ~r[ir[8:6]];
                wr = 1'b1;
            end
            4'b0110: begin
                val = ref_mem[r[ir[8:6]] + sext(ir[5:0], 6)];
                wr = 1'b1;
            end
            4'b0111: begin
                ea = r[ir[8:6]] + sext(ir[5:0], 6);
                ref_mem[ea] = r[ir[11:9]];
                exp_addr_q.push_back(ea);
                exp_data_q.push_back(r[ir[11:9]]);
            end
            4'b0000: if (|(ir[11:9] & cc)) pc = pc + sext(ir[8:0], 9);
            // Return address is the word after the JSR
            4'b0100: begin
                r[7] = pc;
                pc = pc + sext(ir[10:0], 11);
            end
            4'b1100: pc = r[ir[8:6]];
            4'b1101: begin
                exp_led_q.push_back(ir[11:0]);
                if (ir[11:0] == last_code) return;
            end
            default: ;
        endcase
        if (wr) begin
            r[ir[11:9]] = val;
            cc = val[15] ? 3'b100 : ((val == '0) ? 3'b010 : 3'b001);
        end
    end
endfunction

`endif

/* dv/slc3_tb.sv */
//--------------------------------------------------------------------------
// Testbench for the SLC-3 core. Loads program and data into the memory model,
// runs the core, and checks every store and pause against the reference.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module slc3_tb import slc3_pkg::*; ();

    logic        clk;
    logic        reset_i;
    logic        run_i;
    logic        continue_i;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic [11:0] led;
    logic        paused;
    int          errors;
    integer      seed;
    logic [15:0] load_addr;
    int          wait_limit = 400;

    `include "slc3_ref_model.svh"

    slc3_cpu u_slc3_cpu (
        .clk        (clk),
        .reset_i    (reset_i),
        .run_i      (run_i),
        .continue_i (continue_i),
        .wb_rsp_i   (wb_rsp),
        .wb_req_o   (wb_req),
        .led_o      (led),
        .paused_o   (paused)
    );

    slc3_mem_model u_mem (
        .clk      (clk),
        .reset_i  (reset_i),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic store_word(input logic [15:0] addr, input logic [15:0] word);
        u_mem.mem[addr] = word;
        ref_mem[addr] = word;
    endtask

    task automatic emit(input logic [15:0] word);
        store_word(load_addr, word);
        load_addr++;
    endtask

    // Output region starts at 0x4030 and is split by behavior
    function automatic string store_test(input logic [15:0] addr);
        int off;
        off = int'(addr) - 'h4030;
        if (off < 0) return "ldr_str_neg";
        else if (off < 4) return "add_and";
        else if (off < 12) return "not_br";
        else return "jsr_jmp";
    endfunction

    task automatic finish_run();
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic wait_paused(input string what, output bit timed_out);
        int cycles;
        cycles = 0;
        while (!paused && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        timed_out = !paused;
        if (timed_out) begin
            errors++;
            $display("Timeout, the core never reached %s", what);
        end
    endtask

    task automatic wait_fetch(input string what, output bit timed_out);
        int cycles;
        cycles = 0;
        while (!wb_req.cyc && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        timed_out = !wb_req.cyc;
        if (timed_out) begin
            errors++;
            $display("Timeout, no bus cycle after continue from %s", what);
        end
    endtask

    // ------------------------------------------------------------------------
    // Store compare
    // ------------------------------------------------------------------------

    always @(negedge clk) begin : compare_stores
        logic [15:0] exp_a;
        logic [15:0] exp_d;
        if (!reset_i && wb_req.cyc && wb_req.stb && wb_req.we && wb_rsp.ack) begin
            if (exp_addr_q.size() == 0) begin
                errors++;
                $display("Unexpected store of %h to address %h", wb_req.dat, wb_req.adr);
            end else begin
                exp_a = exp_addr_q.pop_front();
                exp_d = exp_data_q.pop_front();
                assert (wb_req.adr == exp_a) else begin
                    errors++;
                    $display("Error: %s address expected %h actual %h",
                             store_test(exp_a), exp_a, wb_req.adr);
                end
                assert (wb_req.dat == exp_d) else begin
                    errors++;
                    $display("Error: %s data expected %h actual %h",
                             store_test(exp_a), exp_d, wb_req.dat);
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin : main
        logic [11:0] code;
        int          idx;
        bit          timed_out;
        reset_i = 1'b1;
        run_i = 1'b0;
        continue_i = 1'b0;
        errors = 0;
        seed = 41;
        repeat (5) @(posedge clk);
        // Pointer words in low memory and operand words at 0x4000
        store_word(16'h0001, 16'h4000);
        store_word(16'h0002, 16'h4030);
        store_word(16'h4000, 16'($random(seed)));
        store_word(16'h4001, 16'($random(seed)));
        load_addr = PC_RESET;
        emit({OP_LDR, 3'd6, 3'd0, 6'd1});
        emit({OP_LDR, 3'd5, 3'd0, 6'd2});
        emit({OP_LDR, 3'd1, 3'd6, 6'd0});
        emit({OP_LDR, 3'd2, 3'd6, 6'd1});
        emit({OP_ADD, 3'd3, 3'd1, 3'b000, 3'd2});
        emit({OP_STR, 3'd3, 3'd5, 6'd0});
        emit({OP_AND, 3'd3, 3'd1, 3'b000, 3'd2});
        emit({OP_STR, 3'd3, 3'd5, 6'd1});
        emit({OP_ADD, 3'd3, 3'd1, 1'b1, 5'h19});
        emit({OP_STR, 3'd3, 3'd5, 6'd2});
        emit({OP_AND, 3'd3, 3'd2, 1'b1, 5'h0D});
        emit({OP_STR, 3'd3, 3'd5, 6'd3});
        emit({OP_NOT, 3'd4, 3'd1, 6'h3F});
        // Negative offsets below the output base
        emit({OP_STR, 3'd4, 3'd5, 6'h3F});
        emit({OP_LDR, 3'd3, 3'd5, 6'h3F});
        emit({OP_STR, 3'd3, 3'd5, 6'h3E});
        // Each BR skips the STR after it when taken
        emit({OP_AND, 3'd3, 3'd3, 1'b1, 5'h00});
        emit({OP_ADD, 3'd4, 3'd3, 1'b1, 5'h1F});
        emit({OP_BR, 3'b100, 9'd1});
        emit({OP_STR, 3'd4, 3'd5, 6'd4});
        emit({OP_BR, 3'b011, 9'd1});
        emit({OP_STR, 3'd4, 3'd5, 6'd5});
        emit({OP_ADD, 3'd4, 3'd3, 1'b1, 5'h00});
        emit({OP_BR, 3'b010, 9'd1});
        emit({OP_STR, 3'd4, 3'd5, 6'd6});
        emit({OP_BR, 3'b101, 9'd1});
        emit({OP_STR, 3'd4, 3'd5, 6'd7});
        emit({OP_ADD, 3'd4, 3'd3, 1'b1, 5'h05});
        emit({OP_BR, 3'b001, 9'd1});
        emit({OP_STR, 3'd4, 3'd5, 6'd8});
        emit({OP_BR, 3'b110, 9'd1});
        emit({OP_STR, 3'd4, 3'd5, 6'd9});
        emit({OP_BR, 3'b111, 9'd1});
        emit({OP_STR, 3'd4, 3'd5, 6'd10});
        emit({OP_BR, 3'b000, 9'd1});
        emit({OP_STR, 3'd4, 3'd5, 6'd11});
        emit({OP_PAUSE, 12'h0A5});
        // Call into the routine at 0x3029 that returns through R7
        emit({OP_JSR, 1'b1, 11'd3});
        emit({OP_ADD, 3'd4, 3'd3, 1'b1, 5'h09});
        emit({OP_STR, 3'd4, 3'd5, 6'd13});
        emit({OP_PAUSE, 12'hFFF});
        emit({OP_ADD, 3'd4, 3'd3, 1'b1, 5'h07});
        emit({OP_STR, 3'd4, 3'd5, 6'd12});
        emit({OP_STR, 3'd7, 3'd5, 6'd14});
        emit({OP_JMP, 3'd0, 3'd7, 6'd0});
        run_reference(12'hFFF, 1000);
        #2 reset_i = 1'b0;

        // Core must stay idle until run
        repeat (8) begin
            @(negedge clk);
            assert (!wb_req.cyc && !paused && led == 12'h000) else begin
                errors++;
                $display("Bus active or pause outputs set before run was given");
            end
        end
        @(posedge clk);
        #2 run_i = 1'b1;
        @(posedge clk);
        #2 run_i = 1'b0;

        idx = 0;
        timed_out = 1'b0;
        while (exp_led_q.size() > 0 && !timed_out) begin
            code = exp_led_q.pop_front();
            wait_paused($sformatf("pause_%0d", idx), timed_out);
            if (!timed_out) begin
                assert (led == code) else begin
                    errors++;
                    $display("Error: pause_%0d expected %h actual %h", idx, code, led);
                end
                if (exp_led_q.size() > 0) begin
                    repeat (6) begin
                        @(negedge clk);
                        assert (paused && !wb_req.cyc) else begin
                            errors++;
                            $display("Core left the pause before continue was given");
                        end
                    end
                    @(posedge clk);
                    #2 continue_i = 1'b1;
                    @(posedge clk);
                    #2 continue_i = 1'b0;
                    wait_fetch($sformatf("pause_%0d", idx), timed_out);
                end
            end
            idx++;
        end

        assert (exp_addr_q.size() == 0) else begin
            errors++;
            $display("%0d expected stores never happened", exp_addr_q.size());
        end
        finish_run();
    end

endmodule

/* src.f */
+incdir+dv
logic/slc3_pkg.sv
logic/slc3_decode.sv
logic/slc3_execute.sv
logic/slc3_result.sv
logic/slc3_cpu.sv
dv/slc3_mem_model.sv
dv/slc3_tb.sv

/* Bender.yml */
package:
  name: slc3

sources:
  - logic/slc3_pkg.sv
  - logic/slc3_decode.sv
  - logic/slc3_execute.sv
  - logic/slc3_result.sv
  - logic/slc3_cpu.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/slc3_mem_model.sv
      - dv/slc3_tb.sv
